//--- board_shell.f
board_shell_pkg.sv
rtc_divider.sv
fan_pwm.sv
pad_adapt.sv
mem_spill_reg.sv
board_shell.sv
tb_board_shell.sv

//--- board_shell.sv
// board shell top level wiring rtc, fan, pad adaption and the memory request slice
module board_shell
  import board_shell_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  // rtc and fan
  output logic       rtc_o,
  input  fan_level_t fan_sw_i,
  output logic       fan_pwm_o,
  // spi host and sd card
  input  logic       spi_sck_i,
  input  logic       spi_sck_en_i,
  input  spi_cs_t    spi_cs_i,
  input  spi_cs_t    spi_cs_en_i,
  input  spi_sd_t    spi_sd_i,
  input  spi_sd_t    spi_sd_en_i,
  output spi_sd_t    spi_sd_o,
  output logic       sd_sclk_o,
  output logic       sd_dat3_o,
  output logic       sd_cmd_o,
  input  logic       sd_dat0_i,
  // i2c
  input  logic       i2c_scl_i,
  input  logic       i2c_scl_en_i,
  input  logic       i2c_sda_i,
  input  logic       i2c_sda_en_i,
  output logic       i2c_scl_o,
  output logic       i2c_sda_o,
  output logic       scl_pad_o,
  output logic       scl_pad_oe_o,
  output logic       sda_pad_o,
  output logic       sda_pad_oe_o,
  input  logic       scl_pad_i,
  input  logic       sda_pad_i,
  // gpio
  input  gpio_t      gpio_i,
  input  logic       gpio_en_i,
  output gpio_t      gpio_o,
  output gpio_t      gpio_pad_o,
  output gpio_t      gpio_pad_oe_o,
  input  gpio_t      gpio_pad_i,
  // memory request, soc side
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  mem_addr_t  req_addr_i,
  input  mem_data_t  req_data_i,
  input  mem_strb_t  req_strb_i,
  input  logic       req_write_i,
  // memory request, dram side
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  output mem_addr_t  mem_addr_o,
  output mem_data_t  mem_data_o,
  output mem_strb_t  mem_strb_o,
  output logic       mem_write_o
);

  ////////////////////////////////////////////////////////////
  // memory request slice toward dram
  ////////////////////////////////////////////////////////////

  // register slice eases timing into the memory controller
  mem_spill_reg i_mem_spill_reg (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_addr_i  ( req_addr_i  ),
    .req_data_i  ( req_data_i  ),
    .req_strb_i  ( req_strb_i  ),
    .req_write_i ( req_write_i ),
    .mem_valid_o ( mem_valid_o ),
    .mem_ready_i ( mem_ready_i ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_data_o  ( mem_data_o  ),
    .mem_strb_o  ( mem_strb_o  ),
    .mem_write_o ( mem_write_o )
  );

  ////////////////////////////////////////////////////////////
  // i2c, spi and gpio pad adaption
  ////////////////////////////////////////////////////////////

  pad_adapt i_pad_adapt (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_n         ),
    .spi_sck_i     ( spi_sck_i     ),
    .spi_sck_en_i  ( spi_sck_en_i  ),
    .spi_cs_i      ( spi_cs_i      ),
    .spi_cs_en_i   ( spi_cs_en_i   ),
    .spi_sd_i      ( spi_sd_i      ),
    .spi_sd_en_i   ( spi_sd_en_i   ),
    .spi_sd_o      ( spi_sd_o      ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_dat3_o     ( sd_dat3_o     ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_dat0_i     ( sd_dat0_i     ),
    .i2c_scl_i     ( i2c_scl_i     ),
    .i2c_scl_en_i  ( i2c_scl_en_i  ),
    .i2c_sda_i     ( i2c_sda_i     ),
    .i2c_sda_en_i  ( i2c_sda_en_i  ),
    .i2c_scl_o     ( i2c_scl_o     ),
    .i2c_sda_o     ( i2c_sda_o     ),
    .scl_pad_o     ( scl_pad_o     ),
    .scl_pad_oe_o  ( scl_pad_oe_o  ),
    .sda_pad_o     ( sda_pad_o     ),
    .sda_pad_oe_o  ( sda_pad_oe_o  ),
    .scl_pad_i     ( scl_pad_i     ),
    .sda_pad_i     ( sda_pad_i     ),
    .gpio_i        ( gpio_i        ),
    .gpio_en_i     ( gpio_en_i     ),
    .gpio_o        ( gpio_o        ),
    .gpio_pad_o    ( gpio_pad_o    ),
    .gpio_pad_oe_o ( gpio_pad_oe_o ),
    .gpio_pad_i    ( gpio_pad_i    )
  );

  ////////////////////////////////////////////////////////////
  // rtc divider and fan control
  ////////////////////////////////////////////////////////////

  // 50 MHz in, 1 MHz rtc out
  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

endmodule

//--- board_shell_pkg.sv
// board shell package holding the shared constants and vector types of the fpga shell
package board_shell_pkg;

  ////////////////////////////////////////////////////////////
  // real-time clock
  ////////////////////////////////////////////////////////////

  // soc_clk cycles between rtc toggles, 50 MHz down to 1 MHz
  localparam int unsigned rtc_half_period = 25;

  // wide enough to count up to rtc_half_period - 1
  typedef logic [4:0] rtc_cnt_t;

  ////////////////////////////////////////////////////////////
  // fan control
  ////////////////////////////////////////////////////////////

  // duty setting in sixteenths, straight from the board switches
  typedef logic [3:0] fan_level_t;

  // soc_clk cycles per pwm step
  localparam int unsigned fan_prescale = 4;

  // pwm steps per fan period
  localparam int unsigned fan_steps = 16;

  ////////////////////////////////////////////////////////////
  // pads
  ////////////////////////////////////////////////////////////

  // flop stages on every pad input into soc_clk
  localparam int unsigned pad_sync_stages = 2;

  // gpio pins, kept at the board width
  typedef logic [29:0] gpio_t;

  // spi host chip selects and their enables
  typedef logic [1:0] spi_cs_t;

  // spi host data lanes and their enables
  typedef logic [3:0] spi_sd_t;

  ////////////////////////////////////////////////////////////
  // memory request path
  ////////////////////////////////////////////////////////////

  // dram byte address, low 30 bits only
  typedef logic [29:0] mem_addr_t;

  // one data beat
  typedef logic [63:0] mem_data_t;

  // byte strobes of a write beat
  typedef logic [7:0] mem_strb_t;

endpackage

//--- fan_pwm.sv
// fan pwm generator turning the 4-bit switch setting into a fan drive signal
module fan_pwm
  import board_shell_pkg::*;
(
  input  logic       soc_clk,
  input  logic       rst_n,
  input  fan_level_t fan_sw_i,
  output logic       fan_pwm_o
);

  // prescaler, one step tick every fan_prescale cycles
  logic [$clog2(fan_prescale)-1:0] pre_q;
  logic                            step_tick;

  // step position within the fan period
  fan_level_t step_q;
  logic       period_wrap;

  // setting in use for the current period
  fan_level_t level_q;

  assign step_tick   = (32'(pre_q) == fan_prescale - 1);
  assign period_wrap = step_tick && (step_q == fan_level_t'(fan_steps - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q <= '0;
    end else if (step_tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // step counter wraps after fan_steps steps
  // new setting only picked up at the wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q  <= '0;
      level_q <= '0;
    end else if (period_wrap) begin
      step_q  <= '0;
      level_q <= fan_sw_i;
    end else if (step_tick) begin
      step_q <= step_q + 1'b1;
    end
  end

  // high for the first level_q steps of each period
  // level 0 keeps the fan off
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_pwm_o <= 1'b0;
    end else begin
      fan_pwm_o <= (step_q < level_q);
    end
  end

endmodule

//--- mem_spill_reg.sv
// memory request spill register, a two-entry valid/ready slice toward the dram
module mem_spill_reg
  import board_shell_pkg::*;
(
  input  logic      soc_clk,
  input  logic      rst_n,
  // soc side
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  mem_addr_t req_addr_i,
  input  mem_data_t req_data_i,
  input  mem_strb_t req_strb_i,
  input  logic      req_write_i,
  // dram side
  output logic      mem_valid_o,
  input  logic      mem_ready_i,
  output mem_addr_t mem_addr_o,
  output mem_data_t mem_data_o,
  output mem_strb_t mem_strb_o,
  output logic      mem_write_o
);

  // output entry, drives the dram side
  logic      out_full_q;
  mem_addr_t out_addr_q;
  mem_data_t out_data_q;
  mem_strb_t out_strb_q;
  logic      out_write_q;

  // spill entry, only used under back-pressure
  logic      spill_full_q;
  mem_addr_t spill_addr_q;
  mem_data_t spill_data_q;
  mem_strb_t spill_strb_q;
  logic      spill_write_q;

  // handshake helpers
  logic req_fire;
  logic out_free;
  logic out_from_spill;
  logic out_from_req;
  logic spill_from_req;

  // spill full implies output full, so this is "both full"
  assign req_ready_o = ~spill_full_q;
  assign req_fire    = req_valid_i & req_ready_o;

  // output entry empty or handing its beat over this cycle
  assign out_free = ~out_full_q | mem_ready_i;

  // older beat in spill goes first
  assign out_from_spill = out_free & spill_full_q;
  assign out_from_req   = out_free & ~spill_full_q & req_fire;
  // output busy and staying busy, park the new beat
  assign spill_from_req = ~out_free & req_fire;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_full_q   <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (out_free) begin
        out_full_q <= spill_full_q | req_fire;
      end
      if (out_from_spill) begin
        spill_full_q <= 1'b0;
      end else if (spill_from_req) begin
        spill_full_q <= 1'b1;
      end
    end
  end

  // payload flops, qualified by the full flags
  always_ff @(posedge soc_clk) begin
    if (out_from_spill) begin
      out_addr_q  <= spill_addr_q;
      out_data_q  <= spill_data_q;
      out_strb_q  <= spill_strb_q;
      out_write_q <= spill_write_q;
    end else if (out_from_req) begin
      out_addr_q  <= req_addr_i;
      out_data_q  <= req_data_i;
      out_strb_q  <= req_strb_i;
      out_write_q <= req_write_i;
    end
    if (spill_from_req) begin
      spill_addr_q  <= req_addr_i;
      spill_data_q  <= req_data_i;
      spill_strb_q  <= req_strb_i;
      spill_write_q <= req_write_i;
    end
  end

  assign mem_valid_o = out_full_q;
  assign mem_addr_o  = out_addr_q;
  assign mem_data_o  = out_data_q;
  assign mem_strb_o  = out_strb_q;
  assign mem_write_o = out_write_q;

endmodule

//--- pad_adapt.sv
// pad adaption mapping the spi host onto the sd card and passing i2c and gpio through
module pad_adapt
  import board_shell_pkg::*;
(
  input  logic    soc_clk,
  input  logic    rst_n,
  // spi host side
  input  logic    spi_sck_i,
  input  logic    spi_sck_en_i,
  input  spi_cs_t spi_cs_i,
  input  spi_cs_t spi_cs_en_i,
  input  spi_sd_t spi_sd_i,
  input  spi_sd_t spi_sd_en_i,
  output spi_sd_t spi_sd_o,
  // sd card pins
  output logic    sd_sclk_o,
  output logic    sd_dat3_o,
  output logic    sd_cmd_o,
  input  logic    sd_dat0_i,
  // i2c soc side
  input  logic    i2c_scl_i,
  input  logic    i2c_scl_en_i,
  input  logic    i2c_sda_i,
  input  logic    i2c_sda_en_i,
  output logic    i2c_scl_o,
  output logic    i2c_sda_o,
  // i2c pads
  output logic    scl_pad_o,
  output logic    scl_pad_oe_o,
  output logic    sda_pad_o,
  output logic    sda_pad_oe_o,
  input  logic    scl_pad_i,
  input  logic    sda_pad_i,
  // gpio soc side
  input  gpio_t   gpio_i,
  input  logic    gpio_en_i,
  output gpio_t   gpio_o,
  // gpio pads
  output gpio_t   gpio_pad_o,
  output gpio_t   gpio_pad_oe_o,
  input  gpio_t   gpio_pad_i
);

  // all pad inputs bundled for one synchronizer chain
  logic [$bits(gpio_t)+2:0] pad_in;
  logic [$bits(gpio_t)+2:0] sync_q [pad_sync_stages];
  logic                     sd_dat0_sync;

  ////////////////////////////////////////////////////////////
  // sd card in spi mode
  ////////////////////////////////////////////////////////////

  // idle high whenever the host is not driving
  assign sd_sclk_o = spi_sck_en_i   ? spi_sck_i   : 1'b1;
  // chip select 0 on dat3
  assign sd_dat3_o = spi_cs_en_i[0] ? spi_cs_i[0] : 1'b1;
  // mosi on cmd
  assign sd_cmd_o  = spi_sd_en_i[0] ? spi_sd_i[0] : 1'b1;

  // miso from dat0 on lane 1, unused lanes read low
  assign spi_sd_o = spi_sd_t'({2'b00, sd_dat0_sync, 1'b0});

  ////////////////////////////////////////////////////////////
  // i2c and gpio outputs
  ////////////////////////////////////////////////////////////

  assign scl_pad_o     = i2c_scl_i;
  assign scl_pad_oe_o  = i2c_scl_en_i;
  assign sda_pad_o     = i2c_sda_i;
  assign sda_pad_oe_o  = i2c_sda_en_i;
  assign gpio_pad_o    = gpio_i;
  // one enable for the whole bank
  assign gpio_pad_oe_o = gpio_t'({$bits(gpio_t){gpio_en_i}});

  // input synchronizers, pad_sync_stages flops deep
  assign pad_in = {sd_dat0_i, scl_pad_i, sda_pad_i, gpio_pad_i};

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < pad_sync_stages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= pad_in;
      for (int i = 1; i < pad_sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // unpack the last stage back onto the soc side
  assign {sd_dat0_sync, i2c_scl_o, i2c_sda_o, gpio_o} = sync_q[pad_sync_stages-1];

endmodule

//--- rtc_divider.sv
// rtc divider turning soc_clk into the slow square real-time clock
module rtc_divider
  import board_shell_pkg::*;
(
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // cycle counter within one half period
  rtc_cnt_t cnt_q;
  // registered clock bit, drives rtc_o directly
  logic     rtc_q;
  // last cycle of the half period
  logic     half_done;

  assign half_done = (cnt_q == rtc_cnt_t'(rtc_half_period - 1));

  // count 0 .. rtc_half_period-1, then clear and flip the clock
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (half_done) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // straight from the flop, so no glitches
  assign rtc_o = rtc_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the board shell testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_board_shell -f board_shell.f \
  && ./obj_dir/Vtb_board_shell > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log

# the testbench reports failure in the log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation PASSED"; exit 0; }

//--- tb_board_shell.sv
// board shell testbench checking rtc, fan pwm, pad paths and the memory request slice
module tb_board_shell
  import board_shell_pkg::*;
();

  // stimulus sizes
  localparam int unsigned mem_beats   = 200;
  localparam int unsigned burst_beats = 16;
  localparam int unsigned pad_cycles  = 60;
  localparam int unsigned rtc_edges   = 20;

  // one memory beat flattened for the scoreboard
  typedef logic [$bits(mem_addr_t)+$bits(mem_data_t)+$bits(mem_strb_t):0] beat_t;

  logic       soc_clk;
  logic       rst_n;
  logic       rtc_o;
  fan_level_t fan_sw_i;
  logic       fan_pwm_o;
  logic       spi_sck_i;
  logic       spi_sck_en_i;
  spi_cs_t    spi_cs_i;
  spi_cs_t    spi_cs_en_i;
  spi_sd_t    spi_sd_i;
  spi_sd_t    spi_sd_en_i;
  spi_sd_t    spi_sd_o;
  logic       sd_sclk_o;
  logic       sd_dat3_o;
  logic       sd_cmd_o;
  logic       sd_dat0_i;
  logic       i2c_scl_i;
  logic       i2c_scl_en_i;
  logic       i2c_sda_i;
  logic       i2c_sda_en_i;
  logic       i2c_scl_o;
  logic       i2c_sda_o;
  logic       scl_pad_o;
  logic       scl_pad_oe_o;
  logic       sda_pad_o;
  logic       sda_pad_oe_o;
  logic       scl_pad_i;
  logic       sda_pad_i;
  gpio_t      gpio_i;
  logic       gpio_en_i;
  gpio_t      gpio_o;
  gpio_t      gpio_pad_o;
  gpio_t      gpio_pad_oe_o;
  gpio_t      gpio_pad_i;
  logic       req_valid_i;
  logic       req_ready_o;
  mem_addr_t  req_addr_i;
  mem_data_t  req_data_i;
  mem_strb_t  req_strb_i;
  logic       req_write_i;
  logic       mem_valid_o;
  logic       mem_ready_i;
  mem_addr_t  mem_addr_o;
  mem_data_t  mem_data_o;
  mem_strb_t  mem_strb_o;
  logic       mem_write_o;

  // error counters, summed up in the closing line
  int unsigned mismatch_errs = 0;
  int unsigned other_errs    = 0;

  // beats accepted upstream and not yet seen downstream
  beat_t       exp_q[$];
  int unsigned rx_count  = 0;
  bit          rtc_done  = 1'b0;

  board_shell DUT (.*);

  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////////////////////////
  // reference models and check helpers
  ////////////////////////////////////////////////////////////

  // high cycles over a number of fan periods
  function automatic int unsigned fan_high_ref(input fan_level_t lvl, input int unsigned periods);
    return 32'(lvl) * fan_prescale * periods;
  endfunction

  // sd pins {sclk, dat3, cmd}, each idles high without its enable
  function automatic logic [2:0] sd_pins_ref(input logic sck, input logic sck_en,
                                             input spi_cs_t cs, input spi_cs_t cs_en,
                                             input spi_sd_t sd, input spi_sd_t sd_en);
    logic [2:0] pins;
    pins[2] = sck   | ~sck_en;
    pins[1] = cs[0] | ~cs_en[0];
    pins[0] = sd[0] | ~sd_en[0];
    return pins;
  endfunction

  function automatic beat_t pack_beat(input mem_addr_t addr, input mem_data_t data,
                                      input mem_strb_t strb, input logic wr);
    return {addr, data, strb, wr};
  endfunction

  task automatic check_value(input bit ok, input string msg);
    assert (ok) else begin
      mismatch_errs++;
      $display("Mismatch at time %0t: %s", $time, msg);
    end
  endtask

  // timeouts and lost progress
  task automatic check_progress(input bit ok, input string msg);
    assert (ok) else begin
      other_errs++;
      $display("Failure at time %0t: %s", $time, msg);
    end
  endtask

  // inputs change 2 units after the rising edge
  task automatic step_to_drive();
    @(posedge soc_clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // rtc edge spacing
  ////////////////////////////////////////////////////////////

  initial begin : rtc_monitor
    int unsigned gap;
    int unsigned edges;
    int unsigned guard;
    logic        last;
    gap   = 0;
    edges = 0;
    guard = 0;
    // first negedge with reset released starts the count
    do begin
      @(negedge soc_clk);
      guard++;
    end while (!rst_n && guard < 100);
    check_progress(rst_n === 1'b1, "reset was never released");
    last = rtc_o;
    check_value(rtc_o === 1'b0, "rtc_o is not low after reset");
    while (edges < rtc_edges && gap <= 2 * rtc_half_period) begin
      @(negedge soc_clk);
      gap++;
      if (rtc_o !== last) begin
        check_value(gap == rtc_half_period,
                    $sformatf("rtc edge %0d came after %0d cycles, expected %0d",
                              edges, gap, rtc_half_period));
        last  = rtc_o;
        gap   = 0;
        edges++;
      end
    end
    check_progress(edges == rtc_edges, "rtc_o stopped toggling");
    rtc_done = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // memory scoreboard
  ////////////////////////////////////////////////////////////

  // a downstream beat transfers at the next edge
  always @(negedge soc_clk) begin : mem_scoreboard
    beat_t got_beat;
    beat_t exp_beat;
    if (rst_n && mem_valid_o && mem_ready_i) begin
      got_beat = pack_beat(mem_addr_o, mem_data_o, mem_strb_o, mem_write_o);
      check_progress(exp_q.size() != 0, "memory beat came out with none outstanding");
      if (exp_q.size() != 0) begin
        exp_beat = exp_q.pop_front();
        check_value(got_beat === exp_beat,
                    $sformatf("memory beat %0d is %h, expected %h", rx_count, got_beat, exp_beat));
      end
      rx_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic run_fan_level(input fan_level_t lvl);
    int unsigned high;
    int unsigned period;
    high   = 0;
    period = fan_prescale * fan_steps;
    fan_sw_i = lvl;
    // new level lands at the next wrap, two periods is plenty
    repeat (2 * period) @(posedge soc_clk);
    repeat (4 * period) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        high++;
      end
    end
    check_value(high == fan_high_ref(lvl, 4),
                $sformatf("fan level %0d gave %0d high cycles, expected %0d",
                          lvl, high, fan_high_ref(lvl, 4)));
    step_to_drive();
  endtask

  task automatic run_pad_paths(input int unsigned n_cycles);
    logic [32:0] pad_q[$];
    logic [32:0] pad_word;
    logic [32:0] exp_word;
    logic [2:0]  exp_sd;
    for (int unsigned i = 0; i < n_cycles; i++) begin
      spi_sck_i    = 1'($urandom);
      spi_sck_en_i = 1'($urandom);
      spi_cs_i     = spi_cs_t'($urandom);
      spi_cs_en_i  = spi_cs_t'($urandom);
      spi_sd_i     = spi_sd_t'($urandom);
      spi_sd_en_i  = spi_sd_t'($urandom);
      i2c_scl_i    = 1'($urandom);
      i2c_scl_en_i = 1'($urandom);
      i2c_sda_i    = 1'($urandom);
      i2c_sda_en_i = 1'($urandom);
      gpio_i       = gpio_t'($urandom);
      gpio_en_i    = 1'($urandom);
      // {dat0, scl, sda, gpio} as seen on the board
      pad_word = {1'($urandom), $urandom};
      {sd_dat0_i, scl_pad_i, sda_pad_i, gpio_pad_i} = pad_word;
      pad_q.push_back(pad_word);
      @(negedge soc_clk);
      // same-cycle outputs
      exp_sd = sd_pins_ref(spi_sck_i, spi_sck_en_i, spi_cs_i, spi_cs_en_i,
                           spi_sd_i, spi_sd_en_i);
      check_value({sd_sclk_o, sd_dat3_o, sd_cmd_o} === exp_sd,
                  $sformatf("sd pins %b, expected %b", {sd_sclk_o, sd_dat3_o, sd_cmd_o}, exp_sd));
      check_value(scl_pad_o === i2c_scl_i && scl_pad_oe_o === i2c_scl_en_i,
                  "scl pad does not follow the soc side");
      check_value(sda_pad_o === i2c_sda_i && sda_pad_oe_o === i2c_sda_en_i,
                  "sda pad does not follow the soc side");
      check_value(gpio_pad_o === gpio_i, $sformatf("gpio_pad_o %h, expected %h", gpio_pad_o, gpio_i));
      check_value(gpio_pad_oe_o === {$bits(gpio_t){gpio_en_i}},
                  $sformatf("gpio_pad_oe_o %h with gpio_en_i %b", gpio_pad_oe_o, gpio_en_i));
      // pad inputs show up two edges after they were driven
      if (pad_q.size() == 3) begin
        exp_word = pad_q.pop_front();
        check_value(spi_sd_o === {2'b00, exp_word[32], 1'b0},
                    $sformatf("spi_sd_o %b, expected miso %b on lane 1", spi_sd_o, exp_word[32]));
        check_value({i2c_scl_o, i2c_sda_o, gpio_o} === exp_word[31:0],
                    $sformatf("synced pads %h, expected %h",
                              {i2c_scl_o, i2c_sda_o, gpio_o}, exp_word[31:0]));
      end
      step_to_drive();
    end
  endtask

  task automatic drive_new_request();
    req_valid_i = 1'b1;
    req_addr_i  = mem_addr_t'($urandom);
    req_data_i  = {$urandom, $urandom};
    req_strb_i  = mem_strb_t'($urandom);
    req_write_i = 1'($urandom);
  endtask

  task automatic run_mem_random(input int unsigned n_beats);
    int unsigned sent;
    int unsigned guard;
    bit          accept;
    sent   = 0;
    guard  = 0;
    accept = 1'b0;
    while (sent < n_beats && guard < 40 * n_beats) begin
      // beat handed over at the last edge
      if (accept) begin
        exp_q.push_back(pack_beat(req_addr_i, req_data_i, req_strb_i, req_write_i));
        sent++;
        req_valid_i = 1'b0;
      end
      // valid rises with fresh payload, then holds until taken
      if (!req_valid_i && sent < n_beats && $urandom_range(0, 9) < 7) begin
        drive_new_request();
      end
      mem_ready_i = ($urandom_range(0, 9) < 6);
      @(negedge soc_clk);
      accept = req_valid_i && req_ready_o;
      step_to_drive();
      guard++;
    end
    req_valid_i = 1'b0;
    check_progress(sent == n_beats,
                   $sformatf("only %0d of %0d memory beats were accepted", sent, n_beats));
  endtask

  // valid and ready held high, one beat per cycle
  task automatic run_mem_burst(input int unsigned n_beats);
    int unsigned taken;
    bit          accept;
    taken       = 0;
    mem_ready_i = 1'b1;
    for (int unsigned i = 0; i < n_beats; i++) begin
      drive_new_request();
      @(negedge soc_clk);
      check_value(req_ready_o === 1'b1, $sformatf("req_ready_o low in burst cycle %0d", i));
      if (i > 0) begin
        check_value(mem_valid_o === 1'b1, $sformatf("mem_valid_o low in burst cycle %0d", i));
      end
      accept = req_valid_i && req_ready_o;
      step_to_drive();
      if (accept) begin
        exp_q.push_back(pack_beat(req_addr_i, req_data_i, req_strb_i, req_write_i));
        taken++;
      end
    end
    req_valid_i = 1'b0;
    check_value(taken == n_beats, $sformatf("burst took %0d of %0d beats", taken, n_beats));
  endtask

  // let the slice empty, then make sure nothing else comes out
  task automatic drain_mem();
    int unsigned guard;
    guard       = 0;
    req_valid_i = 1'b0;
    mem_ready_i = 1'b1;
    while (exp_q.size() != 0 && guard < 50) begin
      step_to_drive();
      guard++;
    end
    check_progress(exp_q.size() == 0,
                   $sformatf("%0d memory beats never came out", exp_q.size()));
    repeat (4) begin
      @(negedge soc_clk);
      check_value(mem_valid_o === 1'b0, "mem_valid_o high with the slice drained");
      check_value(req_ready_o === 1'b1, "req_ready_o low with the slice drained");
    end
    step_to_drive();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned guard;
    guard = 0;
    rst_n        = 1'b0;
    fan_sw_i     = '0;
    spi_sck_i    = 1'b0;
    spi_sck_en_i = 1'b0;
    spi_cs_i     = '0;
    spi_cs_en_i  = '0;
    spi_sd_i     = '0;
    spi_sd_en_i  = '0;
    i2c_scl_i    = 1'b0;
    i2c_scl_en_i = 1'b0;
    i2c_sda_i    = 1'b0;
    i2c_sda_en_i = 1'b0;
    gpio_i       = '0;
    gpio_en_i    = 1'b0;
    // pads high during reset, synced side must still read 0
    sd_dat0_i    = 1'b1;
    scl_pad_i    = 1'b1;
    sda_pad_i    = 1'b1;
    gpio_pad_i   = '1;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_strb_i   = '0;
    req_write_i  = 1'b0;
    mem_ready_i  = 1'b0;
    void'($urandom(32'h6070_73ab));

    repeat (4) @(posedge soc_clk);
    #2;
    rst_n = 1'b1;

    // state straight after reset
    @(negedge soc_clk);
    check_value(fan_pwm_o === 1'b0, "fan_pwm_o not low after reset");
    check_value(req_ready_o === 1'b1, "req_ready_o not high after reset");
    check_value(mem_valid_o === 1'b0, "mem_valid_o not low after reset");
    check_value({i2c_scl_o, i2c_sda_o, gpio_o} === '0, "synced pads not 0 after reset");
    check_value(spi_sd_o === '0, "spi_sd_o not 0 after reset");
    step_to_drive();

    // fan levels, rtc monitor runs alongside
    run_fan_level(fan_level_t'(0));
    run_fan_level(fan_level_t'(5));
    run_fan_level(fan_level_t'(15));

    run_pad_paths(pad_cycles);

    run_mem_random(mem_beats);
    drain_mem();
    run_mem_burst(burst_beats);
    drain_mem();
    check_value(rx_count == mem_beats + burst_beats,
                $sformatf("%0d memory beats out, expected %0d", rx_count, mem_beats + burst_beats));

    while (!rtc_done && guard < 1000) begin
      step_to_drive();
      guard++;
    end
    check_progress(rtc_done, "rtc monitor did not finish");

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
